// File: rtl/common.sv
package common;

    localparam int WORD_W     = 32;
    localparam int REG_W      = 5;
    localparam int DMEM_WORDS = 256;                   // data memory depth in words
    localparam int DMEM_AW    = $clog2(DMEM_WORDS);    // word index width

    typedef logic [WORD_W-1:0]  word_t;       // data or address word
    typedef logic [REG_W-1:0]   regaddr_t;    // register index
    typedef logic [DMEM_AW-1:0] dmem_addr_t;  // data memory word index
    typedef logic [3:0]         byte_en_t;    // one bit per byte lane

    // ALU functions with PASS2 for lui
    typedef enum logic [3:0] {
        ADD   = 4'd0,
        SUB   = 4'd1,
        SLL   = 4'd2,
        SLT   = 4'd3,
        SLTU  = 4'd4,
        XOR   = 4'd5,
        SRL   = 4'd6,
        SRA   = 4'd7,
        OR    = 4'd8,
        AND   = 4'd9,
        PASS2 = 4'd10
    } alu_mode_t;

    typedef enum logic [1:0] {
        MA_X     = 2'd0,    // no memory access
        MA_LOAD  = 2'd1,
        MA_STORE = 2'd2
    } ma_mode_t;

    // same values as the funct3 field of loads and stores
    typedef enum logic [2:0] {
        MA_B  = 3'd0,
        MA_H  = 3'd1,
        MA_W  = 3'd2,
        MA_BU = 3'd4,
        MA_HU = 3'd5
    } ma_size_t;

    typedef enum logic [1:0] {
        WB_SRC_ALU  = 2'd0,
        WB_SRC_MEM  = 2'd1,
        WB_SRC_DATA = 2'd2  // precomputed such as pc+4
    } wb_src_t;

    localparam word_t    NOP_PC       = 32'hffff_ffff;  // reserved pc of a bubble
    localparam word_t    NOP_IR       = 32'h0000_0013;  // addi x0, x0, 0
    localparam ma_mode_t NOP_MA_MODE  = MA_X;
    localparam ma_size_t NOP_MA_SIZE  = MA_W;
    localparam wb_src_t  NOP_WB_SRC   = WB_SRC_ALU;
    localparam logic     NOP_WB_VALID = 1'b0;

endpackage

// File: rtl/alu.sv
`timescale 1ns/1ps

module alu (
    input  wire common::alu_mode_t alu_mode_i,    // function select
    input  wire common::word_t     alu_op1_i,     // operand 1
    input  wire common::word_t     alu_op2_i,     // operand 2
    output common::word_t          alu_result_o   // result
);

    logic [4:0] shamt;    // rv32 shifts use five bits
    logic       lt_s;
    logic       lt_u;

    assign shamt = alu_op2_i[4:0];
    assign lt_s  = $signed(alu_op1_i) < $signed(alu_op2_i);
    assign lt_u  = alu_op1_i < alu_op2_i;

    always_comb begin
        case (alu_mode_i)
            common::ADD:
                alu_result_o = alu_op1_i + alu_op2_i;
            common::SUB:
                alu_result_o = alu_op1_i - alu_op2_i;
            common::SLL:
                alu_result_o = alu_op1_i << shamt;
            common::SLT:
                alu_result_o = {31'b0, lt_s};
            common::SLTU:
                alu_result_o = {31'b0, lt_u};
            common::XOR:
                alu_result_o = alu_op1_i ^ alu_op2_i;
            common::SRL:
                alu_result_o = alu_op1_i >> shamt;
            common::SRA:
                alu_result_o = common::word_t'($signed(alu_op1_i) >>> shamt);  // keeps sign
            common::OR:
                alu_result_o = alu_op1_i | alu_op2_i;
            common::AND:
                alu_result_o = alu_op1_i & alu_op2_i;
            common::PASS2:
                alu_result_o = alu_op2_i;    // lui immediate
            default:
                alu_result_o = '0;
        endcase
    end

endmodule

// File: rtl/cpu_ex.sv
`timescale 1ns/1ps

module cpu_ex (
    input  wire  common::word_t     pc_i,          // program counter
    input  wire  logic              clk_i,
    input  wire  logic              reset_i,
    input  wire  common::word_t     ir_i,          // instruction word
    input  wire  common::word_t     alu_op1_i,
    input  wire  common::word_t     alu_op2_i,
    input  wire  common::alu_mode_t alu_mode_i,
    input  wire  common::ma_mode_t  ma_mode_i,     // memory access mode
    input  wire  common::ma_size_t  ma_size_i,     // memory access size
    input  wire  common::word_t     ma_data_i,     // store data
    input  wire  common::wb_src_t   wb_src_i,      // write-back source
    input  wire  common::word_t     wb_data_i,     // precomputed write-back data
    input  wire  logic              wb_valid_i,

    output common::regaddr_t        fwd_addr_o,    // destination of the op in EX
    output common::word_t           fwd_data_o,
    output logic                    fwd_ready_o,   // low while a load is pending
    output logic                    fwd_valid_o,
    output logic                    empty_o,       // stage holds a bubble

    output common::word_t           pc_o,
    output common::word_t           ir_o,
    output common::word_t           ma_addr_o,
    output common::ma_mode_t        ma_mode_o,
    output common::ma_size_t        ma_size_o,
    output common::word_t           ma_data_o,
    output common::wb_src_t         wb_src_o,
    output common::word_t           wb_data_o,
    output logic                    wb_valid_o
);

    common::word_t alu_result;

    alu alu0 (
        .alu_mode_i   (alu_mode_i),
        .alu_op1_i    (alu_op1_i),
        .alu_op2_i    (alu_op2_i),
        .alu_result_o (alu_result)
    );

    // forwarding view of the op currently in EX
    assign fwd_addr_o  = ir_i[11:7];
    assign fwd_data_o  = (wb_src_i == common::WB_SRC_ALU) ? alu_result : wb_data_i;
    assign fwd_ready_o = (ma_mode_i != common::MA_LOAD);
    assign fwd_valid_o = wb_valid_i;
    assign empty_o     = (pc_i == common::NOP_PC);

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            pc_o       <= common::NOP_PC;
            ir_o       <= common::NOP_IR;
            ma_addr_o  <= '0;
            ma_mode_o  <= common::NOP_MA_MODE;
            ma_size_o  <= common::NOP_MA_SIZE;
            ma_data_o  <= '0;
            wb_src_o   <= common::NOP_WB_SRC;
            wb_data_o  <= '0;
            wb_valid_o <= common::NOP_WB_VALID;
        end else begin
            pc_o       <= pc_i;
            ir_o       <= ir_i;
            ma_addr_o  <= (ma_mode_i == common::MA_X) ? '0 : alu_result;  // base + offset
            ma_mode_o  <= ma_mode_i;
            ma_size_o  <= ma_size_i;
            ma_data_o  <= ma_data_i;
            wb_src_o   <= wb_src_i;
            wb_data_o  <= fwd_data_o;
            wb_valid_o <= wb_valid_i;
        end
    end

endmodule

// File: rtl/data_mem.sv
`timescale 1ns/1ps

module data_mem (
    input  wire logic               clk_i,
    input  wire common::dmem_addr_t addr_i,    // word index
    input  wire logic               we_i,      // write enable
    input  wire common::byte_en_t   be_i,      // byte lanes to write
    input  wire common::word_t      wdata_i,   // lane-aligned write data
    output common::word_t           rdata_o    // valid one cycle after addr_i
);

    common::word_t mem [common::DMEM_WORDS];

    initial begin
        for (int i = 0; i < common::DMEM_WORDS; i++) begin
            mem[i] = '0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (we_i) begin
            for (int b = 0; b < 4; b++) begin
                if (be_i[b]) begin
                    mem[addr_i][8*b +: 8] <= wdata_i[8*b +: 8];
                end
            end
        end
        rdata_o <= mem[addr_i];    // old data on a same-cycle write
    end

endmodule

// File: rtl/cpu_ma.sv
`timescale 1ns/1ps

module cpu_ma (
    input  wire  logic              clk_i,
    input  wire  logic              reset_i,
    input  wire  common::word_t     pc_i,
    input  wire  common::word_t     ir_i,
    input  wire  common::word_t     ma_addr_i,    // byte address
    input  wire  common::ma_mode_t  ma_mode_i,
    input  wire  common::ma_size_t  ma_size_i,
    input  wire  common::word_t     ma_data_i,    // store data in the low bits
    input  wire  common::wb_src_t   wb_src_i,
    input  wire  common::word_t     wb_data_i,
    input  wire  logic              wb_valid_i,
    output common::word_t           pc_o,
    output common::regaddr_t        wb_addr_o,
    output common::word_t           wb_data_o,
    output logic                    wb_valid_o
);

    logic [1:0]         offset;      // byte offset after alignment
    common::byte_en_t   be;
    common::word_t      rdata;
    common::word_t      lane;        // read data shifted down to bit 0
    common::word_t      load_value;
    logic               is_load_q;
    logic [1:0]         offset_q;
    common::ma_size_t   size_q;
    common::word_t      data_q;

    // truncate to natural alignment
    always_comb begin
        case (ma_size_i)
            common::MA_W:               offset = 2'b00;
            common::MA_H, common::MA_HU: offset = {ma_addr_i[1], 1'b0};
            default:                    offset = ma_addr_i[1:0];
        endcase
        case (ma_size_i)
            common::MA_W:               be = 4'b1111;
            common::MA_H, common::MA_HU: be = 4'b0011 << offset;
            default:                    be = 4'b0001 << offset;
        endcase
    end

    data_mem dmem0 (
        .clk_i   (clk_i),
        .addr_i  (ma_addr_i[common::DMEM_AW+1:2]),
        .we_i    (ma_mode_i == common::MA_STORE),
        .be_i    (be),
        .wdata_i (ma_data_i << {offset, 3'b000}),
        .rdata_o (rdata)
    );

    // load alignment and extension one cycle after the read
    assign lane = rdata >> {offset_q, 3'b000};

    always_comb begin
        case (size_q)
            common::MA_B:  load_value = {{24{lane[7]}}, lane[7:0]};
            common::MA_BU: load_value = {24'b0, lane[7:0]};
            common::MA_H:  load_value = {{16{lane[15]}}, lane[15:0]};
            common::MA_HU: load_value = {16'b0, lane[15:0]};
            default:       load_value = lane;
        endcase
    end

    assign wb_data_o = is_load_q ? load_value : data_q;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            pc_o       <= common::NOP_PC;
            wb_addr_o  <= '0;
            wb_valid_o <= common::NOP_WB_VALID;
            is_load_q  <= 1'b0;
            offset_q   <= 2'b00;
            size_q     <= common::NOP_MA_SIZE;
            data_q     <= '0;
        end else begin
            pc_o       <= pc_i;
            wb_addr_o  <= ir_i[11:7];
            wb_valid_o <= wb_valid_i && (ir_i[11:7] != '0)
                          && (ma_mode_i != common::MA_STORE);  // x0 and stores never retire
            is_load_q  <= (wb_src_i == common::WB_SRC_MEM);
            offset_q   <= offset;
            size_q     <= ma_size_i;
            data_q     <= wb_data_i;
        end
    end

endmodule

// File: rtl/cpu_wb.sv
`timescale 1ns/1ps

module cpu_wb (
    input  wire  logic             clk_i,
    input  wire  logic             reset_i,
    input  wire  common::word_t    pc_i,
    input  wire  common::regaddr_t wb_addr_i,     // destination register
    input  wire  common::word_t    wb_data_i,
    input  wire  logic             wb_valid_i,
    input  wire  common::regaddr_t rd_addr_i,     // observation read port
    output common::word_t          rd_data_o,
    output common::word_t          retire_pc_o,
    output common::regaddr_t       retire_addr_o,
    output common::word_t          retire_data_o,
    output logic                   retire_valid_o
);

    common::word_t regs [1:31];    // x0 is not stored

    assign rd_data_o = (rd_addr_i == '0) ? '0 : regs[rd_addr_i];

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_valid_i && (wb_addr_i != '0)) begin
            regs[wb_addr_i] <= wb_data_i;
        end
    end

    // retire record for one cycle per valid op
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            retire_pc_o    <= common::NOP_PC;
            retire_addr_o  <= '0;
            retire_data_o  <= '0;
            retire_valid_o <= 1'b0;
        end else begin
            retire_pc_o    <= pc_i;
            retire_addr_o  <= wb_addr_i;
            retire_data_o  <= wb_data_i;
            retire_valid_o <= wb_valid_i;
        end
    end

endmodule

// File: rtl/cpu_backend.sv
`timescale 1ns/1ps

module cpu_backend (
    input  wire  logic              clk_i,
    input  wire  logic              reset_i,
    input  wire  common::word_t     pc_i,
    input  wire  common::word_t     ir_i,
    input  wire  common::word_t     alu_op1_i,
    input  wire  common::word_t     alu_op2_i,
    input  wire  common::alu_mode_t alu_mode_i,
    input  wire  common::ma_mode_t  ma_mode_i,
    input  wire  common::ma_size_t  ma_size_i,
    input  wire  common::word_t     ma_data_i,
    input  wire  common::wb_src_t   wb_src_i,
    input  wire  common::word_t     wb_data_i,
    input  wire  logic              wb_valid_i,
    output common::regaddr_t        fwd_addr_o,     // for an external hazard unit
    output common::word_t           fwd_data_o,
    output logic                    fwd_ready_o,
    output logic                    fwd_valid_o,
    output logic                    ex_empty_o,
    input  wire  common::regaddr_t  rd_addr_i,
    output common::word_t           rd_data_o,
    output common::word_t           retire_pc_o,
    output common::regaddr_t        retire_addr_o,
    output common::word_t           retire_data_o,
    output logic                    retire_valid_o
);

    common::word_t     ex_pc, ex_ir, ex_ma_addr, ex_ma_data, ex_wb_data;
    common::ma_mode_t  ex_ma_mode;
    common::ma_size_t  ex_ma_size;
    common::wb_src_t   ex_wb_src;
    logic              ex_wb_valid;
    common::word_t     ma_pc, ma_wb_data;
    common::regaddr_t  ma_wb_addr;
    logic              ma_wb_valid;

    cpu_ex ex0 (
        .clk_i (clk_i), .reset_i (reset_i),
        .pc_i (pc_i), .ir_i (ir_i), .alu_op1_i (alu_op1_i), .alu_op2_i (alu_op2_i),
        .alu_mode_i (alu_mode_i), .ma_mode_i (ma_mode_i), .ma_size_i (ma_size_i),
        .ma_data_i (ma_data_i), .wb_src_i (wb_src_i), .wb_data_i (wb_data_i),
        .wb_valid_i (wb_valid_i),
        .fwd_addr_o (fwd_addr_o), .fwd_data_o (fwd_data_o), .fwd_ready_o (fwd_ready_o),
        .fwd_valid_o (fwd_valid_o), .empty_o (ex_empty_o),
        .pc_o (ex_pc), .ir_o (ex_ir), .ma_addr_o (ex_ma_addr), .ma_mode_o (ex_ma_mode),
        .ma_size_o (ex_ma_size), .ma_data_o (ex_ma_data), .wb_src_o (ex_wb_src),
        .wb_data_o (ex_wb_data), .wb_valid_o (ex_wb_valid)
    );

    cpu_ma ma0 (
        .clk_i (clk_i), .reset_i (reset_i),
        .pc_i (ex_pc), .ir_i (ex_ir), .ma_addr_i (ex_ma_addr), .ma_mode_i (ex_ma_mode),
        .ma_size_i (ex_ma_size), .ma_data_i (ex_ma_data), .wb_src_i (ex_wb_src),
        .wb_data_i (ex_wb_data), .wb_valid_i (ex_wb_valid),
        .pc_o (ma_pc), .wb_addr_o (ma_wb_addr), .wb_data_o (ma_wb_data),
        .wb_valid_o (ma_wb_valid)
    );

    cpu_wb wb0 (
        .clk_i (clk_i), .reset_i (reset_i),
        .pc_i (ma_pc), .wb_addr_i (ma_wb_addr), .wb_data_i (ma_wb_data),
        .wb_valid_i (ma_wb_valid),
        .rd_addr_i (rd_addr_i), .rd_data_o (rd_data_o),
        .retire_pc_o (retire_pc_o), .retire_addr_o (retire_addr_o),
        .retire_data_o (retire_data_o), .retire_valid_o (retire_valid_o)
    );

endmodule

// File: test/backend_tb.sv
`timescale 1ns/1ps

module backend_tb;

    // columns of an operation line in the stim file
    localparam int COL_PC = 0, COL_IR = 1, COL_OP1 = 2, COL_OP2 = 3, COL_ALU = 4, COL_MA = 5;
    localparam int COL_SIZE = 6, COL_MDATA = 7, COL_SRC = 8, COL_WDATA = 9, COL_WVALID = 10;
    localparam int COL_FDATA = 11, COL_FREADY = 12, COL_RVALID = 13, COL_RADDR = 14;
    localparam int COL_RDATA = 15;

    typedef logic [31:0] row_t [16];

    logic              clk_i;
    logic              reset_i;
    common::word_t     pc_i, ir_i, alu_op1_i, alu_op2_i, ma_data_i, wb_data_i;
    common::alu_mode_t alu_mode_i;
    common::ma_mode_t  ma_mode_i;
    common::ma_size_t  ma_size_i;
    common::wb_src_t   wb_src_i;
    logic              wb_valid_i;
    common::regaddr_t  rd_addr_i, fwd_addr_o, retire_addr_o;
    common::word_t     fwd_data_o, rd_data_o, retire_pc_o, retire_data_o;
    logic              fwd_ready_o, fwd_valid_o, ex_empty_o, retire_valid_o;

    row_t              ops[$];
    string             names[$];
    common::regaddr_t  reg_addr[$];
    common::word_t     reg_val[$];
    int                pending[$];    // op index per retire slot or -1 for a bubble
    row_t              bubble;
    int                cycles = 0;
    int                cycle_limit = 50;

    cpu_backend dut0 (
        .clk_i (clk_i), .reset_i (reset_i), .pc_i (pc_i), .ir_i (ir_i),
        .alu_op1_i (alu_op1_i), .alu_op2_i (alu_op2_i), .alu_mode_i (alu_mode_i),
        .ma_mode_i (ma_mode_i), .ma_size_i (ma_size_i), .ma_data_i (ma_data_i),
        .wb_src_i (wb_src_i), .wb_data_i (wb_data_i), .wb_valid_i (wb_valid_i),
        .fwd_addr_o (fwd_addr_o), .fwd_data_o (fwd_data_o), .fwd_ready_o (fwd_ready_o),
        .fwd_valid_o (fwd_valid_o), .ex_empty_o (ex_empty_o),
        .rd_addr_i (rd_addr_i), .rd_data_o (rd_data_o),
        .retire_pc_o (retire_pc_o), .retire_addr_o (retire_addr_o),
        .retire_data_o (retire_data_o), .retire_valid_o (retire_valid_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #10 clk_i = ~clk_i;
    end

    always @(posedge clk_i) begin
        cycles <= cycles + 1;
        if (cycles > cycle_limit) begin
            fail_run($sformatf("timeout: run still going after %0d cycles", cycles));
        end
    end

    task automatic fail_run(input string reason);
        $display("%s", reason);
        $display("Something failed");
        $fatal(1, "run stopped");
    endtask

    task automatic check_value(input string test, input string what,
                               input logic [31:0] exp, input logic [31:0] act);
        assert (act === exp) else
            fail_run($sformatf("FAIL %s %s: expected %h, actual %h", test, what, exp, act));
    endtask

    task automatic load_stim();
        int          fd;
        int          n;
        string       line;
        string       name;
        row_t        f;
        fd = $fopen("test/backend_stim.txt", "r");
        if (fd == 0) begin
            fail_run("cannot open test/backend_stim.txt");
        end else begin
            while ($fgets(line, fd) != 0) begin
                cycle_limit++;
                n = $sscanf(line, "%s", name);
                if (n < 1 || name.getc(0) == 8'h23) begin
                    // blank or comment line
                end else if (name == "reg") begin
                    n = $sscanf(line, "%s %h %h", name, f[0], f[1]);
                    assert (n == 3) else fail_run({"malformed reg line: ", line});
                    reg_addr.push_back(f[0][4:0]);
                    reg_val.push_back(f[1]);
                end else begin
                    n = $sscanf(line, "%s %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                                name, f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7],
                                f[8], f[9], f[10], f[11], f[12], f[13], f[14], f[15]);
                    assert (n == 17) else fail_run({"malformed stim line: ", line});
                    names.push_back(name);
                    ops.push_back(f);
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic drive_row(input row_t r);
        pc_i       = r[COL_PC];
        ir_i       = r[COL_IR];
        alu_op1_i  = r[COL_OP1];
        alu_op2_i  = r[COL_OP2];
        alu_mode_i = common::alu_mode_t'(r[COL_ALU][3:0]);
        ma_mode_i  = common::ma_mode_t'(r[COL_MA][1:0]);
        ma_size_i  = common::ma_size_t'(r[COL_SIZE][2:0]);
        ma_data_i  = r[COL_MDATA];
        wb_src_i   = common::wb_src_t'(r[COL_SRC][1:0]);
        wb_data_i  = r[COL_WDATA];
        wb_valid_i = r[COL_WVALID][0];
    endtask

    // same-cycle view of the op in EX
    task automatic check_forward(input string name, input row_t r);
        check_value(name, "fwd_addr", 32'(r[COL_IR][11:7]), 32'(fwd_addr_o));
        check_value(name, "fwd_data", r[COL_FDATA], fwd_data_o);
        check_value(name, "fwd_ready", r[COL_FREADY], 32'(fwd_ready_o));
        check_value(name, "fwd_valid", r[COL_WVALID], 32'(fwd_valid_o));
        check_value(name, "ex_empty", 32'(r[COL_PC] == common::NOP_PC), 32'(ex_empty_o));
    endtask

    task automatic check_retire(input int idx);
        row_t  r;
        string name;
        if (idx < 0) begin
            r    = bubble;
            name = "bubble";
        end else begin
            r    = ops[idx];
            name = names[idx];
        end
        check_value(name, "retire_pc", r[COL_PC], retire_pc_o);
        check_value(name, "retire_valid", r[COL_RVALID], 32'(retire_valid_o));
        if (r[COL_RVALID][0]) begin
            check_value(name, "retire_addr", r[COL_RADDR], 32'(retire_addr_o));
            check_value(name, "retire_data", r[COL_RDATA], retire_data_o);
        end
    endtask

    // check the retire slot and issue op idx or a bubble
    task automatic issue_cycle(input int idx);
        @(posedge clk_i);
        #1;
        check_retire(pending.pop_front());
        pending.push_back(idx);
        if (idx < 0) begin
            drive_row(bubble);
        end else begin
            drive_row(ops[idx]);
        end
        #1;
        if (idx >= 0) begin
            check_forward(names[idx], ops[idx]);
        end
    endtask

    initial begin
        reset_i           = 1'b1;
        rd_addr_i         = '0;
        bubble            = '{default: '0};
        bubble[COL_PC]    = common::NOP_PC;
        bubble[COL_IR]    = common::NOP_IR;
        bubble[COL_MA]    = 32'(common::NOP_MA_MODE);
        bubble[COL_SIZE]  = 32'(common::NOP_MA_SIZE);
        bubble[COL_SRC]   = 32'(common::NOP_WB_SRC);
        drive_row(bubble);
        load_stim();
        repeat (5) @(posedge clk_i);
        #1;
        reset_i = 1'b0;
        repeat (3) pending.push_back(-1);    // stages still hold reset state
        foreach (ops[i]) begin
            issue_cycle(i);
        end
        repeat (3) issue_cycle(-1);          // drain
        foreach (reg_addr[i]) begin
            @(posedge clk_i);
            #1;
            rd_addr_i = reg_addr[i];
            #1;
            check_value("reg", $sformatf("x%0d", reg_addr[i]), reg_val[i], rd_data_o);
        end
        $display("Everything OK");
        $finish;
    end

endmodule

// File: test/backend_stim.txt
# name pc ir op1 op2 alu_mode ma_mode ma_size ma_data wb_src wb_data wb_valid, then expected
# fwd_data fwd_ready retire_valid retire_addr retire_data; "reg" lines: register, final value
add      100 000000b3 5 7 0 0 2 0 0 0 1 0000000c 1 1 01 0000000c
sub      104 00000133 5 7 1 0 2 0 0 0 1 fffffffe 1 1 02 fffffffe
sll      108 000001b3 80000001 21 2 0 2 0 0 0 1 00000002 1 1 03 00000002
slt      10c 00000233 ffffffff 1 3 0 2 0 0 0 1 00000001 1 1 04 00000001
sltu     110 000002b3 ffffffff 1 4 0 2 0 0 0 1 00000000 1 1 05 00000000
xor      114 00000333 f0f0f0f0 ff00ff00 5 0 2 0 0 0 1 0ff00ff0 1 1 06 0ff00ff0
srl      118 000003b3 80000000 4 6 0 2 0 0 0 1 08000000 1 1 07 08000000
sra      11c 00000433 80000000 4 7 0 2 0 0 0 1 f8000000 1 1 08 f8000000
or       120 000004b3 f0f0f0f0 0f0f0000 8 0 2 0 0 0 1 fffff0f0 1 1 09 fffff0f0
and      124 00000533 f0f0f0f0 ff00ff00 9 0 2 0 0 0 1 f000f000 1 1 0a f000f000
lui      128 000005b7 0 12345000 a 0 2 0 0 0 1 12345000 1 1 0b 12345000
nop      ffffffff 00000013 0 0 0 0 2 0 0 0 0 00000000 1 0 00 00000000
link     12c 000000ef 0 0 0 0 2 0 2 130 1 00000130 1 1 01 00000130
x0_write 130 00500013 5 5 0 0 2 0 0 0 1 0000000a 1 0 00 00000000
sw       134 00000023 40 0 0 2 2 11223344 0 0 0 00000040 1 0 00 00000000
lw       138 00000603 40 0 0 1 2 0 1 0 1 00000000 0 1 0c 11223344
sb       13c 000000a3 40 1 0 2 0 000000a5 0 0 0 00000041 1 0 00 00000000
lb       140 00000683 40 1 0 1 0 0 1 0 1 00000000 0 1 0d ffffffa5
lbu      144 00000703 40 1 0 1 4 0 1 0 1 00000000 0 1 0e 000000a5
nop      ffffffff 00000013 0 0 0 0 2 0 0 0 0 00000000 1 0 00 00000000
sh       148 00000123 40 2 0 2 1 00008001 0 0 0 00000042 1 0 00 00000000
lh       14c 00000783 40 2 0 1 1 0 1 0 1 00000000 0 1 0f ffff8001
lhu      150 00000803 40 2 0 1 5 0 1 0 1 00000000 0 1 10 00008001
lw_after 154 00000883 40 0 0 1 2 0 1 0 1 00000000 0 1 11 8001a544
lh_mis   158 00000903 40 3 0 1 1 0 1 0 1 00000000 0 1 12 ffff8001
lb_low   15c 00000983 40 0 0 1 0 0 1 0 1 00000000 0 1 13 00000044
lw_x0    160 00000003 40 0 0 1 2 0 1 0 1 00000000 0 0 00 00000000
reg 01 00000130
reg 00 00000000
reg 08 f8000000
reg 0c 11223344
reg 11 8001a544

// File: tb.f
rtl/common.sv
rtl/alu.sv
rtl/cpu_ex.sv
rtl/data_mem.sv
rtl/cpu_ma.sv
rtl/cpu_wb.sv
rtl/cpu_backend.sv
test/backend_tb.sv

// File: run.sh
#!/bin/sh
# build and run the backend testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f tb.f --top-module backend_tb -o backend_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/backend_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx "Everything OK"; then
    exit 0
fi
echo "pass message not found"
exit 1
